/* mips_core.f */
verilog/mips_isa_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/regfile.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/bus_ctrl.sv
verilog/pipe_ctrl.sv
verilog/mips_core.sv
tests/tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
PASS_MSG  := Test completed successfully
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* tests/tb_mips_core_input.txt */
# I <addr> <instruction>, D <addr> <data word>, E <store addr> <store data>
# Hex values; E lines in the order the stores must appear on the bus
I 00000000 3C011234
I 00000004 34215678
I 00000008 24020300
I 0000000C AC410000
I 00000010 2403FFFB
I 00000014 00232021
I 00000018 AC440004
I 0000001C 00812823
I 00000020 00A13024
I 00000024 00C33826
I 00000028 00E24025
I 0000002C 00E1482A
I 00000030 AC450008
I 00000034 AC46000C
I 00000038 AC470010
I 0000003C AC480014
I 00000040 AC490018
I 00000044 8C0A0200
I 00000048 254B0001
I 0000004C 8C0C0204
I 00000050 AC4C001C
I 00000054 AC4B0020
I 00000058 116A0002
I 0000005C AC410024
I 00000060 15200002
I 00000064 AC430028
I 00000068 AC40002C
I 0000006C 10840002
I 00000070 AC44002C
I 00000074 AC400030
I 00000078 14260002
I 0000007C AC480030
I 00000080 AC490034
I 00000084 1000FFFF
I 00000088 00000000
D 00000200 A5A50001
D 00000204 00000040
E 00000300 12345678
E 00000304 12345673
E 00000308 FFFFFFFB
E 0000030C 12345678
E 00000310 EDCBA983
E 00000314 EDCBAB83
E 00000318 00000001
E 0000031C 00000040
E 00000320 A5A50002
E 00000324 12345678
E 00000328 FFFFFFFB
E 0000032C 12345673
E 00000330 EDCBAB83
E 00000334 00000001

/* tests/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;

	localparam int MEM_DEPTH = 1024;
	localparam int ACK_DELAY_MAX = 3;
	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam logic [31:0] HALT_WORD = 32'h1000_ffff;

	logic clk_i;
	logic rst_n_i;
	logic [31:0] wb_data_i;
	logic wb_ack_i;
	logic [31:0] wb_addr_o;
	logic [31:0] wb_data_o;
	logic wb_we_o;
	logic wb_cyc_o;
	logic wb_stb_o;
	logic [3:0] wb_sel_o;

	logic [31:0] mem [MEM_DEPTH];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] halt_addr;
	logic have_halt;
	logic first_access;
	logic [7:0] lfsr;
	int errors;
	int n_inst;
	int exp_idx;
	int halt_fetches;
	int cycle_limit;
	int cycles = 0;

	mips_core #(.RESET_PC(RESET_PC)) dut (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.wb_data_i(wb_data_i),
		.wb_ack_i(wb_ack_i),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o),
		.wb_we_o(wb_we_o),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_sel_o(wb_sel_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	always @(posedge clk_i) cycles <= cycles + 1;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [1:0] rand_bits(input int n);
		logic fb;
		logic [1:0] v;
		v = 2'b00;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
			lfsr = {lfsr[6:0], fb};
			v = {v[0], fb};
		end
		return v;
	endfunction

	task automatic load_input();
		int fd;
		int r;
		string line;
		string rest;
		logic [31:0] a;
		logic [31:0] d;
		fd = $fopen("tests/tb_mips_core_input.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the input file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (line.len() < 3 || line[0] == "#")
				continue;
			rest = line.substr(2, line.len() - 1);
			r = $sscanf(rest, "%h %h", a, d);
			case (line[0])
				"I": begin
					mem[a[11:2]] = d;
					n_inst++;
					if (d == HALT_WORD) begin
						halt_addr = a;
						have_halt = 1'b1;
					end
				end
				"D": mem[a[11:2]] = d;
				"E": begin
					exp_addr.push_back(a);
					exp_data.push_back(d);
				end
				default: ;
			endcase
		end
		$fclose(fd);
	endtask

	task automatic store_seen(input logic [31:0] a, input logic [31:0] d);
		if (exp_idx >= exp_addr.size()) begin
			$display("ERROR: unexpected store of %h to %h at %0t", d, a, $time);
			errors++;
		end else begin
			check("store wb_addr_o", a, exp_addr[exp_idx]);
			check("store wb_data_o", d, exp_data[exp_idx]);
			exp_idx++;
		end
		mem[a[11:2]] = d;
	endtask

	// Memory slave acks after 1 to ACK_DELAY_MAX cycles
	initial begin : bus_model
		logic [31:0] a;
		logic [31:0] d;
		logic we;
		logic [3:0] sel;
		logic [1:0] bits;
		int delay;
		forever begin
			@(posedge clk_i);
			#1;
			if (rst_n_i && wb_stb_o) begin
				a = wb_addr_o;
				d = wb_data_o;
				we = wb_we_o;
				sel = wb_sel_o;
				if (first_access) begin
					check("wb_addr_o first", a, RESET_PC);
					first_access = 1'b0;
				end
				check("wb_cyc_o", {31'b0, wb_cyc_o}, 32'd1);
				check("wb_sel_o", {28'b0, sel}, 32'h0000_000f);
				bits = rand_bits(2);
				delay = (bits == 2'd0) ? 1 : int'(bits);
				if (delay > ACK_DELAY_MAX)
					delay = ACK_DELAY_MAX;
				for (int i = 1; i < delay; i++) begin
					@(posedge clk_i);
					#1;
					check("wb_cyc_o held", {31'b0, wb_cyc_o}, 32'd1);
					check("wb_stb_o held", {31'b0, wb_stb_o}, 32'd1);
					check("wb_addr_o held", wb_addr_o, a);
					check("wb_data_o held", wb_data_o, d);
					check("wb_we_o held", {31'b0, wb_we_o}, {31'b0, we});
					check("wb_sel_o held", {28'b0, wb_sel_o}, {28'b0, sel});
				end
				if (we) begin
					store_seen(a, d);
				end else begin
					wb_data_i = mem[a[11:2]];
					if (have_halt && a == halt_addr)
						halt_fetches++;
				end
				wb_ack_i = 1'b1;
				@(posedge clk_i);
				#1;
				wb_ack_i = 1'b0;
			end
		end
	end

	initial begin
		errors = 0;
		n_inst = 0;
		exp_idx = 0;
		halt_fetches = 0;
		have_halt = 1'b0;
		halt_addr = '0;
		first_access = 1'b1;
		lfsr = 8'd12;
		rst_n_i = 1'b0;
		wb_ack_i = 1'b0;
		wb_data_i = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
			mem[i] = 32'hfeed_0000 | (i << 2);
		load_input();
		cycle_limit = n_inst * 16 + 200;

		repeat (5) begin
			@(posedge clk_i);
			#1;
			check("wb_cyc_o in reset", {31'b0, wb_cyc_o}, 32'd0);
			check("wb_stb_o in reset", {31'b0, wb_stb_o}, 32'd0);
			check("wb_we_o in reset", {31'b0, wb_we_o}, 32'd0);
		end
		rst_n_i = 1'b1;
		check("wb_cyc_o after reset", {31'b0, wb_cyc_o}, 32'd0);
		check("wb_stb_o after reset", {31'b0, wb_stb_o}, 32'd0);
		check("wb_we_o after reset", {31'b0, wb_we_o}, 32'd0);

		// Final loop is fetched again and again once reached
		while (halt_fetches < 3 && cycles < cycle_limit)
			@(posedge clk_i);
		if (halt_fetches < 3) begin
			$display("ERROR: run did not finish within %0d cycles", cycle_limit);
			errors++;
		end else if (exp_idx != exp_addr.size()) begin
			$display("ERROR: only %0d of %0d expected stores seen", exp_idx, exp_addr.size());
			errors++;
		end
		$display("Errors: %0d, stores matched: %0d of %0d", errors, exp_idx, exp_addr.size());
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verilog/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_isa_pkg::*, mips_pipe_pkg::*; #(
	parameter logic [31:0] RESET_PC = RESET_VECTOR
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [DATA_W-1:0] wb_data_i,
	input  logic              wb_ack_i,
	output logic [DATA_W-1:0] wb_addr_o,
	output logic [DATA_W-1:0] wb_data_o,
	output logic              wb_we_o,
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output logic [SEL_W-1:0]  wb_sel_o
);

	stall_t stall;

	logic [DATA_W-1:0] fetch_pc;
	logic [DATA_W-1:0] fetch_inst;
	logic fetch_done;
	logic fetch_busy;
	logic data_busy;

	logic [DATA_W-1:0] id_pc;
	logic [DATA_W-1:0] id_inst;
	logic branch;
	logic [DATA_W-1:0] branch_target;

	logic [REG_ADDR_W-1:0] rs_addr;
	logic [REG_ADDR_W-1:0] rt_addr;
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] rt_data;

	// ID/EX
	alu_op_e idex_aluop;
	logic [DATA_W-1:0] idex_opa;
	logic [DATA_W-1:0] idex_opb;
	logic [DATA_W-1:0] idex_store_data;
	logic idex_wreg;
	logic idex_load;
	logic idex_store;
	logic [REG_ADDR_W-1:0] idex_wd;

	// Forwarding from EX and MEM
	logic fw_ex_wreg;
	logic [REG_ADDR_W-1:0] fw_ex_wd;
	logic [DATA_W-1:0] fw_ex_wdata;
	logic fw_ex_load;
	logic fw_mem_wreg;
	logic [REG_ADDR_W-1:0] fw_mem_wd;
	logic [DATA_W-1:0] fw_mem_wdata;

	// EX/MEM
	logic [DATA_W-1:0] exmem_result;
	logic [DATA_W-1:0] exmem_store_data;
	logic exmem_load;
	logic exmem_store;
	logic exmem_wreg;
	logic [REG_ADDR_W-1:0] exmem_wd;

	logic dreq;
	logic dwe;
	logic [DATA_W-1:0] daddr;
	logic [DATA_W-1:0] dwdata;
	logic [DATA_W-1:0] load_data;

	// MEM/WB
	logic wb_we;
	logic [REG_ADDR_W-1:0] wb_waddr;
	logic [DATA_W-1:0] wb_wdata;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.stall_i(stall),
		.branch_i(branch),
		.branch_target_i(branch_target),
		.fetch_done_i(fetch_done),
		.fetch_inst_i(fetch_inst),
		.fetch_pc_o(fetch_pc),
		.id_pc_o(id_pc),
		.id_inst_o(id_inst)
	);

	decode_stage u_decode (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.stall_i(stall),
		.pc_i(id_pc),
		.inst_i(id_inst),
		.rs_data_i(rs_data),
		.rt_data_i(rt_data),
		.ex_wreg_i(fw_ex_wreg),
		.ex_wd_i(fw_ex_wd),
		.ex_wdata_i(fw_ex_wdata),
		.mem_wreg_i(fw_mem_wreg),
		.mem_wd_i(fw_mem_wd),
		.mem_wdata_i(fw_mem_wdata),
		.rs_addr_o(rs_addr),
		.rt_addr_o(rt_addr),
		.branch_o(branch),
		.branch_target_o(branch_target),
		.ex_aluop_o(idex_aluop),
		.ex_opa_o(idex_opa),
		.ex_opb_o(idex_opb),
		.ex_store_data_o(idex_store_data),
		.ex_wreg_o(idex_wreg),
		.ex_load_o(idex_load),
		.ex_store_o(idex_store),
		.ex_wd_o(idex_wd)
	);

	regfile u_regfile (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.we_i(wb_we),
		.waddr_i(wb_waddr),
		.wdata_i(wb_wdata),
		.raddr1_i(rs_addr),
		.raddr2_i(rt_addr),
		.rdata1_o(rs_data),
		.rdata2_o(rt_data)
	);

	execute_stage u_execute (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.stall_i(stall),
		.aluop_i(idex_aluop),
		.opa_i(idex_opa),
		.opb_i(idex_opb),
		.store_data_i(idex_store_data),
		.wreg_i(idex_wreg),
		.load_i(idex_load),
		.store_i(idex_store),
		.wd_i(idex_wd),
		.ex_wreg_o(fw_ex_wreg),
		.ex_wd_o(fw_ex_wd),
		.ex_wdata_o(fw_ex_wdata),
		.ex_load_o(fw_ex_load),
		.result_o(exmem_result),
		.store_data_o(exmem_store_data),
		.load_o(exmem_load),
		.store_o(exmem_store),
		.wreg_o(exmem_wreg),
		.wd_o(exmem_wd)
	);

	mem_stage u_mem (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.stall_i(stall),
		.result_i(exmem_result),
		.store_data_i(exmem_store_data),
		.load_i(exmem_load),
		.store_i(exmem_store),
		.wreg_i(exmem_wreg),
		.wd_i(exmem_wd),
		.load_data_i(load_data),
		.dreq_o(dreq),
		.dwe_o(dwe),
		.daddr_o(daddr),
		.dwdata_o(dwdata),
		.mem_wreg_o(fw_mem_wreg),
		.mem_wd_o(fw_mem_wd),
		.mem_wdata_o(fw_mem_wdata),
		.wb_we_o(wb_we),
		.wb_waddr_o(wb_waddr),
		.wb_wdata_o(wb_wdata)
	);

	bus_ctrl u_bus (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.fetch_pc_i(fetch_pc),
		.dreq_i(dreq),
		.dwe_i(dwe),
		.daddr_i(daddr),
		.dwdata_i(dwdata),
		.wb_data_i(wb_data_i),
		.wb_ack_i(wb_ack_i),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o),
		.wb_we_o(wb_we_o),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_sel_o(wb_sel_o),
		.fetch_inst_o(fetch_inst),
		.fetch_done_o(fetch_done),
		.load_data_o(load_data),
		.fetch_busy_o(fetch_busy),
		.data_busy_o(data_busy)
	);

	pipe_ctrl u_pipe_ctrl (
		.ex_load_i(fw_ex_load),
		.ex_wd_i(fw_ex_wd),
		.rs_addr_i(rs_addr),
		.rt_addr_i(rt_addr),
		.fetch_busy_i(fetch_busy),
		.data_busy_i(data_busy),
		.stall_o(stall)
	);

endmodule

/* verilog/pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  logic                  ex_load_i,
	input  logic [REG_ADDR_W-1:0] ex_wd_i,
	input  logic [REG_ADDR_W-1:0] rs_addr_i,
	input  logic [REG_ADDR_W-1:0] rt_addr_i,
	input  logic                  fetch_busy_i,
	input  logic                  data_busy_i,
	output stall_t                stall_o
);

	logic load_use;

	assign load_use = ex_load_i && ex_wd_i != '0 &&
		(ex_wd_i == rs_addr_i || ex_wd_i == rt_addr_i);

	// Bus freeze overrides the load-use bubble
	always_comb begin
		if (fetch_busy_i || data_busy_i)
			stall_o = STALL_ALL;
		else if (load_use)
			stall_o = STALL_LOAD_USE;
		else
			stall_o = STALL_NONE;
	end

endmodule

/* verilog/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [DATA_W-1:0] fetch_pc_i,
	input  logic              dreq_i,
	input  logic              dwe_i,
	input  logic [DATA_W-1:0] daddr_i,
	input  logic [DATA_W-1:0] dwdata_i,
	input  logic [DATA_W-1:0] wb_data_i,
	input  logic              wb_ack_i,
	output logic [DATA_W-1:0] wb_addr_o,
	output logic [DATA_W-1:0] wb_data_o,
	output logic              wb_we_o,
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output logic [SEL_W-1:0]  wb_sel_o,
	output logic [DATA_W-1:0] fetch_inst_o,
	output logic              fetch_done_o,
	output logic [DATA_W-1:0] load_data_o,
	output logic              fetch_busy_o,
	output logic              data_busy_o
);

	bus_state_e state;
	logic data_done;
	logic start_data;

	// MEM access of the current slot goes first, once
	assign start_data = dreq_i && !data_done;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= BUS_IDLE;
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			wb_we_o <= 1'b0;
			data_done <= 1'b0;
		end else begin
			case (state)
				BUS_IDLE: begin
					wb_cyc_o <= 1'b1;
					wb_stb_o <= 1'b1;
					wb_we_o <= start_data && dwe_i;
					state <= start_data ? BUS_DATA : BUS_FETCH;
				end
				BUS_FETCH: begin
					if (wb_ack_i) begin
						state <= BUS_IDLE;
						wb_cyc_o <= 1'b0;
						wb_stb_o <= 1'b0;
						data_done <= 1'b0;
					end
				end
				BUS_DATA: begin
					if (wb_ack_i) begin
						state <= BUS_IDLE;
						wb_cyc_o <= 1'b0;
						wb_stb_o <= 1'b0;
						wb_we_o <= 1'b0;
						data_done <= 1'b1;
					end
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == BUS_IDLE) begin
			wb_addr_o <= start_data ? daddr_i : fetch_pc_i;
			wb_data_o <= dwdata_i;
		end
		if (state == BUS_DATA && wb_ack_i) begin
			load_data_o <= wb_data_i;
		end
	end

	assign wb_sel_o = '1;

	// The pipeline advances on the edge that ends a fetch
	assign fetch_done_o = state == BUS_FETCH && wb_ack_i;
	assign fetch_inst_o = wb_data_i;
	assign fetch_busy_o = state != BUS_DATA && !fetch_done_o;
	assign data_busy_o = state == BUS_DATA;

	a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_stb_o && !wb_ack_i |=> $stable(wb_addr_o));

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  stall_t                stall_i,
	input  logic [DATA_W-1:0]     result_i,
	input  logic [DATA_W-1:0]     store_data_i,
	input  logic                  load_i,
	input  logic                  store_i,
	input  logic                  wreg_i,
	input  logic [REG_ADDR_W-1:0] wd_i,
	input  logic [DATA_W-1:0]     load_data_i,
	output logic                  dreq_o,
	output logic                  dwe_o,
	output logic [DATA_W-1:0]     daddr_o,
	output logic [DATA_W-1:0]     dwdata_o,
	output logic                  mem_wreg_o,
	output logic [REG_ADDR_W-1:0] mem_wd_o,
	output logic [DATA_W-1:0]     mem_wdata_o,
	output logic                  wb_we_o,
	output logic [REG_ADDR_W-1:0] wb_waddr_o,
	output logic [DATA_W-1:0]     wb_wdata_o
);

	assign dreq_o = load_i || store_i;
	assign dwe_o = store_i;
	assign daddr_o = result_i;
	assign dwdata_o = store_data_i;

	assign mem_wreg_o = wreg_i;
	assign mem_wd_o = wd_i;
	assign mem_wdata_o = load_i ? load_data_i : result_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || (stall_i[ST_MEM] && !stall_i[ST_WB])) begin
			wb_we_o <= 1'b0;
		end else if (!stall_i[ST_MEM]) begin
			wb_we_o <= wreg_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall_i[ST_MEM]) begin
			wb_waddr_o <= wd_i;
			wb_wdata_o <= mem_wdata_o;
		end
	end

	a_daddr_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dreq_o |-> daddr_o[1:0] == 2'b00);

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  stall_t                stall_i,
	input  alu_op_e               aluop_i,
	input  logic [DATA_W-1:0]     opa_i,
	input  logic [DATA_W-1:0]     opb_i,
	input  logic [DATA_W-1:0]     store_data_i,
	input  logic                  wreg_i,
	input  logic                  load_i,
	input  logic                  store_i,
	input  logic [REG_ADDR_W-1:0] wd_i,
	output logic                  ex_wreg_o,
	output logic [REG_ADDR_W-1:0] ex_wd_o,
	output logic [DATA_W-1:0]     ex_wdata_o,
	output logic                  ex_load_o,
	output logic [DATA_W-1:0]     result_o,
	output logic [DATA_W-1:0]     store_data_o,
	output logic                  load_o,
	output logic                  store_o,
	output logic                  wreg_o,
	output logic [REG_ADDR_W-1:0] wd_o
);

	logic [DATA_W-1:0] alu_res;

	// Loads and stores use ADD for the address
	always_comb begin
		case (aluop_i)
			ALU_ADD: alu_res = opa_i + opb_i;
			ALU_SUB: alu_res = opa_i - opb_i;
			ALU_AND: alu_res = opa_i & opb_i;
			ALU_OR:  alu_res = opa_i | opb_i;
			ALU_XOR: alu_res = opa_i ^ opb_i;
			ALU_SLT: alu_res = {31'b0, $signed(opa_i) < $signed(opb_i)};
			ALU_LUI: alu_res = {opb_i[15:0], 16'h0000};
			default: alu_res = '0;
		endcase
	end

	assign ex_wreg_o = wreg_i;
	assign ex_wd_o = wd_i;
	assign ex_wdata_o = alu_res;
	assign ex_load_o = load_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || (stall_i[ST_EX] && !stall_i[ST_MEM])) begin
			load_o <= 1'b0;
			store_o <= 1'b0;
			wreg_o <= 1'b0;
		end else if (!stall_i[ST_EX]) begin
			load_o <= load_i;
			store_o <= store_i;
			wreg_o <= wreg_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall_i[ST_EX]) begin
			result_o <= alu_res;
			store_data_o <= store_data_i;
			wd_o <= wd_i;
		end
	end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  stall_t                stall_i,
	input  logic [DATA_W-1:0]     pc_i,
	input  logic [DATA_W-1:0]     inst_i,
	input  logic [DATA_W-1:0]     rs_data_i,
	input  logic [DATA_W-1:0]     rt_data_i,
	input  logic                  ex_wreg_i,
	input  logic [REG_ADDR_W-1:0] ex_wd_i,
	input  logic [DATA_W-1:0]     ex_wdata_i,
	input  logic                  mem_wreg_i,
	input  logic [REG_ADDR_W-1:0] mem_wd_i,
	input  logic [DATA_W-1:0]     mem_wdata_i,
	output logic [REG_ADDR_W-1:0] rs_addr_o,
	output logic [REG_ADDR_W-1:0] rt_addr_o,
	output logic                  branch_o,
	output logic [DATA_W-1:0]     branch_target_o,
	output alu_op_e               ex_aluop_o,
	output logic [DATA_W-1:0]     ex_opa_o,
	output logic [DATA_W-1:0]     ex_opb_o,
	output logic [DATA_W-1:0]     ex_store_data_o,
	output logic                  ex_wreg_o,
	output logic                  ex_load_o,
	output logic                  ex_store_o,
	output logic [REG_ADDR_W-1:0] ex_wd_o
);

	opcode_e opcode;
	funct_e funct;
	logic [DATA_W-1:0] imm_sext;
	logic [DATA_W-1:0] imm_zext;
	logic [DATA_W-1:0] rs_val;
	logic [DATA_W-1:0] rt_val;
	alu_op_e aluop;
	logic [DATA_W-1:0] opb;
	logic wreg;
	logic load;
	logic store;
	logic [REG_ADDR_W-1:0] wd;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign funct = funct_e'(inst_i[5:0]);
	assign rs_addr_o = inst_i[25:21];
	assign rt_addr_o = inst_i[20:16];
	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_zext = {16'h0000, inst_i[15:0]};

	// EX result is newer than MEM, so it wins
	function automatic logic [DATA_W-1:0] fwd(
		input logic [REG_ADDR_W-1:0] addr,
		input logic [DATA_W-1:0]     rf_data
	);
		logic [DATA_W-1:0] val;
		if (addr == '0)
			val = '0;
		else if (ex_wreg_i && ex_wd_i == addr)
			val = ex_wdata_i;
		else if (mem_wreg_i && mem_wd_i == addr)
			val = mem_wdata_i;
		else
			val = rf_data;
		return val;
	endfunction

	always_comb begin
		rs_val = fwd(rs_addr_o, rs_data_i);
		rt_val = fwd(rt_addr_o, rt_data_i);
	end

	always_comb begin
		aluop = ALU_NOP;
		opb = rt_val;
		wreg = 1'b0;
		load = 1'b0;
		store = 1'b0;
		wd = inst_i[20:16];
		case (opcode)
			OP_SPECIAL: begin
				wd = inst_i[15:11];
				wreg = 1'b1;
				case (funct)
					FN_ADDU: aluop = ALU_ADD;
					FN_SUBU: aluop = ALU_SUB;
					FN_AND:  aluop = ALU_AND;
					FN_OR:   aluop = ALU_OR;
					FN_XOR:  aluop = ALU_XOR;
					FN_SLT:  aluop = ALU_SLT;
					default: wreg = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				aluop = ALU_ADD;
				opb = imm_sext;
				wreg = 1'b1;
			end
			OP_ORI: begin
				aluop = ALU_OR;
				opb = imm_zext;
				wreg = 1'b1;
			end
			OP_LUI: begin
				aluop = ALU_LUI;
				opb = imm_zext;
				wreg = 1'b1;
			end
			OP_LW: begin
				aluop = ALU_ADD;
				opb = imm_sext;
				wreg = 1'b1;
				load = 1'b1;
			end
			OP_SW: begin
				aluop = ALU_ADD;
				opb = imm_sext;
				store = 1'b1;
			end
			default: ;
		endcase
	end

	// Branch target is relative to the delay slot
	assign branch_o = (opcode == OP_BEQ && rs_val == rt_val) ||
		(opcode == OP_BNE && rs_val != rt_val);
	assign branch_target_o = pc_i + 32'd4 + {imm_sext[DATA_W-3:0], 2'b00};

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || (stall_i[ST_ID] && !stall_i[ST_EX])) begin
			ex_aluop_o <= ALU_NOP;
			ex_wreg_o <= 1'b0;
			ex_load_o <= 1'b0;
			ex_store_o <= 1'b0;
		end else if (!stall_i[ST_ID]) begin
			ex_aluop_o <= aluop;
			ex_wreg_o <= wreg;
			ex_load_o <= load;
			ex_store_o <= store;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall_i[ST_ID]) begin
			ex_opa_o <= rs_val;
			ex_opb_o <= opb;
			ex_store_data_o <= rt_val;
			ex_wd_o <= wd;
		end
	end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import mips_isa_pkg::*, mips_pipe_pkg::*; #(
	parameter logic [31:0] RESET_PC = RESET_VECTOR
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  stall_t            stall_i,
	input  logic              branch_i,
	input  logic [DATA_W-1:0] branch_target_i,
	input  logic              fetch_done_i,
	input  logic [DATA_W-1:0] fetch_inst_i,
	output logic [DATA_W-1:0] fetch_pc_o,
	output logic [DATA_W-1:0] id_pc_o,
	output logic [DATA_W-1:0] id_inst_o
);

	logic [DATA_W-1:0] pc;

	assign fetch_pc_o = pc;

	// Branch in decode redirects the fetch after its delay slot
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc <= RESET_PC;
		end else if (fetch_done_i && !stall_i[ST_PC]) begin
			pc <= branch_i ? branch_target_i : pc + 32'd4;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			id_inst_o <= '0;
		end else if (stall_i[ST_IF] && !stall_i[ST_ID]) begin
			id_inst_o <= '0;
		end else if (fetch_done_i && !stall_i[ST_IF]) begin
			id_inst_o <= fetch_inst_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fetch_done_i && !stall_i[ST_IF]) begin
			id_pc_o <= pc;
		end
	end

	a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		fetch_done_i |=> pc[1:0] == 2'b00);

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile import mips_isa_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  we_i,
	input  logic [REG_ADDR_W-1:0] waddr_i,
	input  logic [DATA_W-1:0]     wdata_i,
	input  logic [REG_ADDR_W-1:0] raddr1_i,
	input  logic [REG_ADDR_W-1:0] raddr2_i,
	output logic [DATA_W-1:0]     rdata1_o,
	output logic [DATA_W-1:0]     rdata2_o
);

	logic [DATA_W-1:0] regs [1 << REG_ADDR_W];
	logic wr_en;

	assign wr_en = rst_n_i && we_i && waddr_i != '0;

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Write-through so decode sees this cycle's write-back
	assign rdata1_o = (raddr1_i == '0) ? '0 :
		(wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 :
		(wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

/* verilog/mips_pipe_pkg.sv */
package mips_pipe_pkg;

	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// A set bit holds that point and every point before it
	typedef logic [5:0] stall_t;

	localparam int ST_PC = 0;
	localparam int ST_IF = 1;
	localparam int ST_ID = 2;
	localparam int ST_EX = 3;
	localparam int ST_MEM = 4;
	localparam int ST_WB = 5;

	localparam stall_t STALL_NONE = 6'b000000;
	localparam stall_t STALL_LOAD_USE = 6'b000111;
	localparam stall_t STALL_ALL = 6'b111111;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_FETCH,
		BUS_DATA
	} bus_state_e;

endpackage

/* verilog/mips_isa_pkg.sv */
package mips_isa_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SEL_W = 4;

	// Default first fetch address
	localparam logic [DATA_W-1:0] RESET_VECTOR = 32'h0000_0000;

	// Primary opcodes, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDIU   = 6'b001001,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	// SPECIAL function codes, inst[5:0]
	typedef enum logic [5:0] {
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} funct_e;

endpackage
